// File: list.f
rtl/bp_pkg.sv
rtl/pht_wr_if.sv
rtl/index_hash.sv
rtl/global_history.sv
rtl/count_pipeline.sv
rtl/pht_update_writer.sv
rtl/pht_write_arbiter.sv
rtl/pattern_table.sv
rtl/history_predictor.sv
test/tb_clock.sv
test/tb_history_predictor.sv

// File: rtl/bp_pkg.sv
package bp_pkg;

  // Two-bit saturating direction counter, the top bit predicts taken
  typedef logic [1:0] cnt_t;

  // Instruction address as seen by fetch, id and ex
  typedef logic [31:0] pc_t;

  // Weakly not taken
  localparam cnt_t CNT_INIT = 2'd1;

  localparam cnt_t CNT_MAX = 2'd3;
  localparam cnt_t CNT_MIN = 2'd0;

endpackage

// File: rtl/count_pipeline.sv
`timescale 1ns/10ps

module count_pipeline
  import bp_pkg::*;
#(
  parameter int HR_WIDTH    = 6,
  parameter int INDEX_WIDTH = 8
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stall,
  input  logic                   rollback_id,
  input  pc_t                    pc_id,
  input  logic [HR_WIDTH+1:0]    history,
  input  cnt_t                   pred_count,
  output cnt_t                   pred_count_id,
  output cnt_t                   pred_count_ex,
  pht_wr_if.writer               rst_wr,
  output logic [INDEX_WIDTH-1:0] rst_index
);

  // The id branch was hashed with the history one shift older than now
  index_hash #(
    .HR_WIDTH    (HR_WIDTH),
    .INDEX_WIDTH (INDEX_WIDTH)
  ) u_id_hash (
    .pc    (pc_id),
    .hr    (history[HR_WIDTH:1]),
    .index (rst_index)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pred_count_id <= '0;
      pred_count_ex <= '0;
    end else if (!stall) begin
      pred_count_id <= pred_count;
      pred_count_ex <= pred_count_id;
    end
  end

  // A squashed id branch gives back the counter value it read at fetch
  assign rst_wr.req   = rollback_id;
  assign rst_wr.index = rst_index;
  assign rst_wr.count = pred_count_id;

endmodule

// File: rtl/global_history.sv
`timescale 1ns/10ps

module global_history #(
  parameter int HR_WIDTH = 6
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                corrected_en,
  input  logic                corrected_result,
  input  logic                rollback_id,
  input  logic                rollback_ex,
  output logic [HR_WIDTH+1:0] history,
  output logic                branch_failed
);

  localparam int HR_DEPTH = HR_WIDTH + 2;

  logic [HR_DEPTH-1:0] history_ex;

  // Two extra bits cover the branches still in id and ex.
  // An id rollback squashes the youngest bit, so the ex branch moves to bit 0
  assign history_ex    = history >> rollback_id;
  assign branch_failed = history_ex[0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      history <= '0;
    end else if (rollback_ex) begin
      history <= {history_ex[HR_DEPTH-1:1], ~branch_failed};
    end else if (corrected_en) begin
      history <= {history[HR_DEPTH-2:0], corrected_result};
    end
  end

endmodule

// File: rtl/history_predictor.sv
`timescale 1ns/10ps

module history_predictor
  import bp_pkg::*;
#(
  parameter int INDEX_WIDTH = 8,
  parameter int HR_WIDTH    = 6
) (
  input  logic clk,
  input  logic rst_n,
  input  logic stall,
  input  logic corrected_en,
  input  logic corrected_result,
  input  logic rollback_id,
  input  logic rollback_ex,
  input  pc_t  pc,
  input  pc_t  pc_id,
  input  pc_t  pc_ex,
  output cnt_t pred_count,
  output cnt_t pred_count_id,
  output cnt_t pred_count_ex
);

  logic [HR_WIDTH+1:0]    history;
  logic                   branch_failed;
  logic [INDEX_WIDTH-1:0] rd_index;
  logic                   wr_en;
  logic [INDEX_WIDTH-1:0] wr_index;
  cnt_t                   wr_count;

  pht_wr_if #(.INDEX_WIDTH(INDEX_WIDTH)) upd_wr ();
  pht_wr_if #(.INDEX_WIDTH(INDEX_WIDTH)) rst_wr ();

  global_history #(.HR_WIDTH(HR_WIDTH)) u_history (
    .clk              (clk),
    .rst_n            (rst_n),
    .corrected_en     (corrected_en),
    .corrected_result (corrected_result),
    .rollback_id      (rollback_id),
    .rollback_ex      (rollback_ex),
    .history          (history),
    .branch_failed    (branch_failed)
  );

  // Fetch lookup uses the newest history bits
  index_hash #(.HR_WIDTH(HR_WIDTH), .INDEX_WIDTH(INDEX_WIDTH)) u_rd_hash (
    .pc    (pc),
    .hr    (history[HR_WIDTH-1:0]),
    .index (rd_index)
  );

  pattern_table #(.INDEX_WIDTH(INDEX_WIDTH)) u_table (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_index (rd_index),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_count (wr_count),
    .rd_count (pred_count)
  );

  count_pipeline #(.HR_WIDTH(HR_WIDTH), .INDEX_WIDTH(INDEX_WIDTH)) u_counts (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall         (stall),
    .rollback_id   (rollback_id),
    .pc_id         (pc_id),
    .history       (history),
    .pred_count    (pred_count),
    .pred_count_id (pred_count_id),
    .pred_count_ex (pred_count_ex),
    .rst_wr        (rst_wr.writer),
    .rst_index     ()
  );

  pht_update_writer #(.HR_WIDTH(HR_WIDTH), .INDEX_WIDTH(INDEX_WIDTH)) u_update (
    .rollback_id      (rollback_id),
    .rollback_ex      (rollback_ex),
    .corrected_en     (corrected_en),
    .corrected_result (corrected_result),
    .branch_failed    (branch_failed),
    .pc               (pc),
    .pc_ex            (pc_ex),
    .history          (history),
    .pred_count       (pred_count),
    .pred_count_ex    (pred_count_ex),
    .upd_wr           (upd_wr.writer),
    .ex_index         ()
  );

  pht_write_arbiter #(.INDEX_WIDTH(INDEX_WIDTH)) u_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .upd_wr   (upd_wr.arbiter),
    .rst_wr   (rst_wr.arbiter),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_count (wr_count)
  );

endmodule

// File: rtl/index_hash.sv
`timescale 1ns/10ps

module index_hash
  import bp_pkg::*;
#(
  parameter int HR_WIDTH    = 6,
  parameter int INDEX_WIDTH = 8
) (
  input  pc_t                    pc,
  input  logic [HR_WIDTH-1:0]    hr,
  output logic [INDEX_WIDTH-1:0] index
);

  // Word-aligned PC, so bits 1:0 never take part
  if (HR_WIDTH >= INDEX_WIDTH) begin : g_xor
    logic [HR_WIDTH-1:0] mixed;

    assign mixed = hr ^ pc[HR_WIDTH+1:2];

    if (HR_WIDTH == INDEX_WIDTH) begin : g_exact
      assign index = mixed;
    end else begin : g_fold
      localparam int EXCESS = HR_WIDTH - INDEX_WIDTH;

      // Bits above the index wrap around onto the low bits
      for (genvar i = 0; i < INDEX_WIDTH; i++) begin : g_bit
        assign index[i] = mixed[i] ^ mixed[INDEX_WIDTH + (i % EXCESS)];
      end
    end
  end else begin : g_concat
    // Short history sits in the low bits with PC bits stacked above it
    assign index = {pc[INDEX_WIDTH-HR_WIDTH+1:2], hr};
  end

endmodule

// File: rtl/pattern_table.sv
`timescale 1ns/10ps

module pattern_table
  import bp_pkg::*;
#(
  parameter int INDEX_WIDTH = 8
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [INDEX_WIDTH-1:0] rd_index,
  input  logic                   wr_en,
  input  logic [INDEX_WIDTH-1:0] wr_index,
  input  cnt_t                   wr_count,
  output cnt_t                   rd_count
);

  localparam int DEPTH = 2 ** INDEX_WIDTH;

  cnt_t counters [DEPTH];

  // Every counter starts out weakly not taken
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        counters[i] <= CNT_INIT;
      end
    end else if (wr_en) begin
      counters[wr_index] <= wr_count;
    end
  end

  // Same-cycle writes are not forwarded
  assign rd_count = counters[rd_index];

endmodule

// File: rtl/pht_update_writer.sv
`timescale 1ns/10ps

module pht_update_writer
  import bp_pkg::*;
#(
  parameter int HR_WIDTH    = 6,
  parameter int INDEX_WIDTH = 8
) (
  input  logic                   rollback_id,
  input  logic                   rollback_ex,
  input  logic                   corrected_en,
  input  logic                   corrected_result,
  input  logic                   branch_failed,
  input  pc_t                    pc,
  input  pc_t                    pc_ex,
  input  logic [HR_WIDTH+1:0]    history,
  input  cnt_t                   pred_count,
  input  cnt_t                   pred_count_ex,
  pht_wr_if.writer               upd_wr,
  output logic [INDEX_WIDTH-1:0] ex_index
);

  logic [INDEX_WIDTH-1:0] fetch_index;
  logic [INDEX_WIDTH-1:0] ex_index_rid;
  logic [INDEX_WIDTH-1:0] ex_index_nrid;
  cnt_t                   ex_count;
  cnt_t                   fetch_count;

  function automatic cnt_t cnt_step(input cnt_t c, input logic up);
    if (up) begin
      return (c == CNT_MAX) ? CNT_MAX : c + 2'd1;
    end
    return (c == CNT_MIN) ? CNT_MIN : c - 2'd1;
  endfunction

  index_hash #(.HR_WIDTH(HR_WIDTH), .INDEX_WIDTH(INDEX_WIDTH)) u_fetch_hash (
    .pc    (pc),
    .hr    (history[HR_WIDTH-1:0]),
    .index (fetch_index)
  );

  // With an id rollback in the same cycle the ex branch sits one place lower
  index_hash #(.HR_WIDTH(HR_WIDTH), .INDEX_WIDTH(INDEX_WIDTH)) u_ex_rid_hash (
    .pc    (pc_ex),
    .hr    (history[HR_WIDTH+1:2]),
    .index (ex_index_rid)
  );

  index_hash #(.HR_WIDTH(HR_WIDTH), .INDEX_WIDTH(INDEX_WIDTH)) u_ex_nrid_hash (
    .pc    (pc_ex),
    .hr    (history[HR_WIDTH:1]),
    .index (ex_index_nrid)
  );

  assign ex_index = rollback_id ? ex_index_rid : ex_index_nrid;

  // The ex branch went the other way from its recorded bit
  assign ex_count    = cnt_step(pred_count_ex, branch_failed);
  assign fetch_count = cnt_step(pred_count, ~corrected_result);

  assign upd_wr.req   = rollback_ex | corrected_en;
  assign upd_wr.index = rollback_ex ? ex_index : fetch_index;
  assign upd_wr.count = rollback_ex ? ex_count : fetch_count;

endmodule

// File: rtl/pht_wr_if.sv
`timescale 1ns/10ps

// One write request into the pattern table, with its same-cycle grant
interface pht_wr_if
  import bp_pkg::*;
#(
  parameter int INDEX_WIDTH = 8
) ();

  logic                   req;
  logic [INDEX_WIDTH-1:0] index;
  cnt_t                   count;
  logic                   grant;

  modport writer (output req, output index, output count, input grant);

  modport arbiter (input req, input index, input count, output grant);

endinterface

// File: rtl/pht_write_arbiter.sv
`timescale 1ns/10ps

module pht_write_arbiter
  import bp_pkg::*;
#(
  parameter int INDEX_WIDTH = 8
) (
  input  logic                   clk,
  input  logic                   rst_n,
  pht_wr_if.arbiter              upd_wr,
  pht_wr_if.arbiter              rst_wr,
  output logic                   wr_en,
  output logic [INDEX_WIDTH-1:0] wr_index,
  output cnt_t                   wr_count
);

  logic                   slot_valid;
  logic [INDEX_WIDTH-1:0] slot_index;
  cnt_t                   slot_count;
  logic                   slot_go;
  logic                   rst_lost;

  // Order is update, then the parked restore, then a new restore
  assign upd_wr.grant = upd_wr.req;
  assign slot_go      = slot_valid & ~upd_wr.req;
  assign rst_wr.grant = rst_wr.req & ~upd_wr.req & ~slot_valid;
  assign rst_lost     = rst_wr.req & ~rst_wr.grant;

  assign wr_en    = upd_wr.req | slot_go | rst_wr.grant;
  assign wr_index = upd_wr.req ? upd_wr.index : (slot_valid ? slot_index : rst_wr.index);
  assign wr_count = upd_wr.req ? upd_wr.count : (slot_valid ? slot_count : rst_wr.count);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slot_valid <= 1'b0;
    end else if (rst_lost) begin
      // An update to the same counter makes the restored value stale
      slot_valid <= ~(upd_wr.req && upd_wr.index == rst_wr.index);
    end else if (slot_go || (upd_wr.req && upd_wr.index == slot_index)) begin
      slot_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_lost) begin
      slot_index <= rst_wr.index;
      slot_count <= rst_wr.count;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the predictor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_history_predictor \
  -f list.f -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' sim.log; then
  exit 1
fi
exit 0

// File: test/tb_clock.sv
`timescale 1ns/10ps

// Free-running testbench clock, low for the first half period
module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: test/tb_history_predictor.sv
`timescale 1ns/10ps

module tb_history_predictor
  import bp_pkg::*;
();

  localparam int INDEX_WIDTH  = 8;
  localparam int HR_WIDTH     = 6;
  localparam int DEPTH        = 2 ** INDEX_WIDTH;
  localparam int RESET_CYCLES = 10;
  localparam int N_RANDOM     = 2000;
  // Tests 1 to 5 take 68 cycles, plus one idle cycle before and one after
  localparam int DIRECTED     = 70;
  localparam int MAX_CYCLES   = RESET_CYCLES + DIRECTED + N_RANDOM + 100;

  logic clk;
  logic rst_n;
  logic stall;
  logic corrected_en;
  logic corrected_result;
  logic rollback_id;
  logic rollback_ex;
  pc_t  pc;
  pc_t  pc_id;
  pc_t  pc_ex;
  cnt_t pred_count;
  cnt_t pred_count_id;
  cnt_t pred_count_ex;

  // Reference state
  logic [HR_WIDTH+1:0]    m_hist;
  cnt_t                   m_table [DEPTH];
  cnt_t                   m_id;
  cnt_t                   m_ex;
  logic                   m_slot_valid;
  logic [INDEX_WIDTH-1:0] m_slot_index;
  cnt_t                   m_slot_count;

  int n_checks = 0;
  int n_errors = 0;
  int err_mark = 0;
  int cycles   = 0;
  int seed;

  tb_clock #(.PERIOD_NS(40)) u_clock (.clk(clk));

  history_predictor #(.INDEX_WIDTH(INDEX_WIDTH), .HR_WIDTH(HR_WIDTH)) dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .stall            (stall),
    .corrected_en     (corrected_en),
    .corrected_result (corrected_result),
    .rollback_id      (rollback_id),
    .rollback_ex      (rollback_ex),
    .pc               (pc),
    .pc_id            (pc_id),
    .pc_ex            (pc_ex),
    .pred_count       (pred_count),
    .pred_count_id    (pred_count_id),
    .pred_count_ex    (pred_count_ex)
  );

  // History is narrower than the index, so PC bits from bit 2 sit above it
  function automatic logic [INDEX_WIDTH-1:0] ref_index(input pc_t p,
                                                       input logic [HR_WIDTH-1:0] h);
    return {p[INDEX_WIDTH-HR_WIDTH+1:2], h};
  endfunction

  function automatic cnt_t saturate_step(input cnt_t c, input logic up);
    if (up) begin
      return (c == CNT_MAX) ? c : cnt_t'(c + 1);
    end else begin
      return (c == CNT_MIN) ? c : cnt_t'(c - 1);
    end
  endfunction

  function automatic cnt_t expected_count(input pc_t p);
    return m_table[ref_index(p, m_hist[HR_WIDTH-1:0])];
  endfunction

  task automatic model_reset();
    m_hist       = '0;
    m_id         = '0;
    m_ex         = '0;
    m_slot_valid = 1'b0;
    m_slot_index = '0;
    m_slot_count = CNT_INIT;
    for (int i = 0; i < DEPTH; i++) begin
      m_table[i] = CNT_INIT;
    end
  endtask

  // Advances the reference by one clock edge with the inputs now applied
  task automatic model_step();
    logic [HR_WIDTH+1:0]    hist_ex;
    logic                   failed;
    logic                   upd_req;
    logic [INDEX_WIDTH-1:0] upd_index;
    cnt_t                   upd_count;
    logic [INDEX_WIDTH-1:0] rst_index;
    logic                   slot_write;
    cnt_t                   fetched;
    hist_ex   = rollback_id ? (m_hist >> 1) : m_hist;
    failed    = hist_ex[0];
    fetched   = expected_count(pc);
    upd_req   = rollback_ex | corrected_en;
    rst_index = ref_index(pc_id, m_hist[HR_WIDTH:1]);
    if (rollback_ex) begin
      upd_index = ref_index(pc_ex, hist_ex[HR_WIDTH:1]);
      upd_count = saturate_step(m_ex, failed);
    end else begin
      upd_index = ref_index(pc, m_hist[HR_WIDTH-1:0]);
      upd_count = saturate_step(fetched, !corrected_result);
    end
    slot_write = m_slot_valid && !upd_req;
    if (upd_req) begin
      m_table[upd_index] = upd_count;
    end else if (m_slot_valid) begin
      m_table[m_slot_index] = m_slot_count;
    end else if (rollback_id) begin
      m_table[rst_index] = m_id;
    end
    // A restore that loses is parked unless the winning update hits its counter
    if (rollback_id && (upd_req || m_slot_valid)) begin
      m_slot_valid = !(upd_req && upd_index == rst_index);
      m_slot_index = rst_index;
      m_slot_count = m_id;
    end else if (slot_write || (upd_req && upd_index == m_slot_index)) begin
      m_slot_valid = 1'b0;
    end
    if (!stall) begin
      m_ex = m_id;
      m_id = fetched;
    end
    if (rollback_ex) begin
      m_hist = {hist_ex[HR_WIDTH+1:1], !failed};
    end else if (corrected_en) begin
      m_hist = {m_hist[HR_WIDTH:0], corrected_result};
    end
  endtask

  task automatic check_cnt(input string name, input cnt_t got, input cnt_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic finish_test(input string name);
    $display("%-22s %s, %0d mismatches", name,
             (n_errors == err_mark) ? "ok" : "bad", n_errors - err_mark);
    err_mark = n_errors;
  endtask

  task automatic drive(input logic st, input logic ce, input logic cr, input logic rid,
                       input logic rex, input pc_t p, input pc_t pid, input pc_t pex);
    @(negedge clk);
    stall            = st;
    corrected_en     = ce;
    corrected_result = cr;
    rollback_id      = rid;
    rollback_ex      = rex;
    pc               = p;
    pc_id            = pid;
    pc_ex            = pex;
  endtask

  // Reads every PC column of the table so pending writes show up
  task automatic sweep_reads();
    for (int k = 0; k < 4; k++) begin
      drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, pc_t'(k << 2), '0, '0);
    end
  endtask

  always @(negedge clk) begin
    #10;
    if (!rst_n) begin
      model_reset();
    end else begin
      check_cnt("pred_count", pred_count, expected_count(pc));
      check_cnt("pred_count_id", pred_count_id, m_id);
      check_cnt("pred_count_ex", pred_count_ex, m_ex);
      model_step();
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    cnt_t held_id;
    cnt_t held_ex;
    int   r;
    seed             = 40445;
    rst_n            = 1'b0;
    stall            = 1'b0;
    corrected_en     = 1'b0;
    corrected_result = 1'b0;
    rollback_id      = 1'b0;
    rollback_ex      = 1'b0;
    pc               = '0;
    pc_id            = '0;
    pc_ex            = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    #5;
    check_cnt("pred_count_id", pred_count_id, '0);
    check_cnt("pred_count_ex", pred_count_ex, '0);

    for (int i = 0; i < 8; i++) begin
      drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, pc_t'($random(seed)), '0, '0);
      #5;
      check_cnt("pred_count", pred_count, CNT_INIT);
    end
    finish_test("reset state");

    // Taken corrections fill the history with ones, then zeros bring it back
    repeat (12) drive(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 32'h1234, '0, '0);
    drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h1234, '0, '0);
    #5;
    check_cnt("pred_count", pred_count, CNT_MIN);
    repeat (12) drive(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h1234, '0, '0);
    drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h1234, '0, '0);
    #5;
    check_cnt("pred_count", pred_count, CNT_MAX);
    finish_test("saturation");

    drive(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 32'h4, '0, '0);
    #5;
    held_id = m_id;
    held_ex = m_ex;
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      drive(1'b1, 1'b1, r[0], 1'b0, 1'b0, pc_t'(r), '0, '0);
      #5;
      check_cnt("pred_count_id", pred_count_id, held_id);
      check_cnt("pred_count_ex", pred_count_ex, held_ex);
    end
    repeat (4) drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, pc_t'($random(seed)), '0, '0);
    finish_test("stall hold");

    drive(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 32'h8, '0, '0);
    drive(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 32'hc, '0, '0);
    drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h0, '0, 32'h8);
    sweep_reads();
    finish_test("ex rollback");

    drive(1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 32'h0, 32'h4, 32'hc);
    sweep_reads();
    // Uniform history makes the id and ex indices equal for the same PC
    repeat (8) drive(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h4, '0, '0);
    drive(1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 32'h0, 32'h4, 32'h4);
    sweep_reads();
    finish_test("id and ex rollback");

    for (int i = 0; i < N_RANDOM; i++) begin
      r = $random(seed);
      drive(r[1:0] == 2'd0, r[4:2] < 3'd3, r[5], r[9:7] == 3'd0, r[12:10] == 3'd0,
            pc_t'($random(seed)), pc_t'($random(seed)), pc_t'($random(seed)));
    end
    finish_test("random mix");

    drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    #15;
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
